//--- hdl/pwr_seq_pkg.sv
/*
 * Power sequencer definitions
 * Rail count, settle and watchdog spans, status register map,
 * ID constants and the shared rail and register types
 */
package pwr_seq_pkg;

	// Sequenced rails, bit 0 comes up first
	localparam int NUM_RAILS = 15;

	typedef logic [NUM_RAILS-1:0] rail_vec_t;

	// Spans scaled down for simulation
	// Hardware uses roughly 2^16 settle and 2^23 watchdog cycles
	localparam int DELAY_CYCLES = 32;
	localparam int WDOG_CYCLES  = 256;
	localparam int DELAY_W      = $clog2(DELAY_CYCLES);
	localparam int WDOG_W       = $clog2(WDOG_CYCLES);

	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Register map
	localparam reg_addr_t ADDR_VERSION = 8'h00;
	localparam reg_addr_t ADDR_CLR_ERR = 8'h03;
	localparam reg_addr_t ADDR_PG_HI   = 8'h05;
	localparam reg_addr_t ADDR_PG_LO   = 8'h06;
	localparam reg_addr_t ADDR_STATUS  = 8'h07;
	localparam reg_addr_t ADDR_VENDOR0 = 8'h0C;
	localparam reg_addr_t ADDR_VENDOR1 = 8'h0D;
	localparam reg_addr_t ADDR_VENDOR2 = 8'h0E;
	localparam reg_addr_t ADDR_VENDOR3 = 8'h0F;

	// Identification
	localparam reg_data_t FPGA_VERSION = 8'h06;

	// "RCS " with the first character at index 0
	localparam logic [0:3][7:0] VENDOR_ID = {8'h52, 8'h43, 8'h53, 8'h20};

	// Read back at the clear address
	localparam reg_data_t CLR_ERR_READBACK = 8'hFF;

	// Status byte layout, MSB first
	typedef struct packed {
		logic [2:0] rsvd;
		logic       wait_err;
		logic       operation_err;
		logic       err_found;
		logic       sysen;
		logic       sysgood;
	} status_bits_t;

endpackage

//--- hdl/seq_status_if.sv
`timescale 1ns/100ps
/*
 * Sequencer status bus
 * Synchronized inputs, fault flags and the error-clear pulse
 */
interface seq_status_if;
	import pwr_seq_pkg::*;

	rail_vec_t pg;
	logic      sysen;
	logic      sysgood;
	logic      wait_err;
	logic      operation_err;
	logic      err_found;
	// One-cycle pulse from the register bank
	logic      clear_err;

	modport sequencer (
		output pg, sysen, sysgood, wait_err, operation_err, err_found,
		input  clear_err
	);

	modport regs (
		input  pg, sysen, sysgood, wait_err, operation_err, err_found,
		output clear_err
	);

endinterface

//--- hdl/rail_sequencer.sv
`timescale 1ns/100ps
/*
 * Rail sequencer
 * Brings rails up one after another behind a settle delay, takes them
 * down behind the rail above, and latches watchdog and operation faults
 */
module rail_sequencer (
	input  logic                   clk_in,
	input  logic                   arst_n,
	input  logic                   sysen,
	input  pwr_seq_pkg::rail_vec_t rail_pg,
	output pwr_seq_pkg::rail_vec_t rail_en,
	seq_status_if.sequencer        status
);
	import pwr_seq_pkg::*;

	rail_vec_t          pg_s1;
	rail_vec_t          pg_s2;
	logic               sysen_s1;
	logic               sysen_s2;
	rail_vec_t          done;
	rail_vec_t          done_below;
	rail_vec_t          pg_above;
	rail_vec_t          timing_vec;
	rail_vec_t          timing_sel;
	rail_vec_t          wait_vec;
	logic [DELAY_W-1:0] d_count;
	logic [WDOG_W-1:0]  w_count;
	logic               timers_clr;
	logic               wdog_expired;
	logic               wait_err;
	logic               operation_err;
	logic               err_found;

	// Two-flop synchronizers
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			pg_s1    <= '0;
			pg_s2    <= '0;
			sysen_s1 <= 1'b0;
			sysen_s2 <= 1'b0;
		end else begin
			pg_s1    <= rail_pg;
			pg_s2    <= pg_s1;
			sysen_s1 <= sysen;
			sysen_s2 <= sysen_s1;
		end
	end

	// Rail i looks at done of rail i-1 and power-good of rail i+1
	assign done_below = {done[NUM_RAILS-2:0], 1'b1};
	assign pg_above   = {1'b0, pg_s2[NUM_RAILS-1:1]};

	// Up the chain behind done flags, down the chain behind power-good
	assign rail_en = (({NUM_RAILS{sysen_s2}} & done_below) | pg_above)
		& ~{NUM_RAILS{err_found}};

	// Lowest rail that is up but not settled owns the delay counter
	assign timing_vec = rail_en & pg_s2 & ~done;
	assign timing_sel = timing_vec & (~timing_vec + rail_vec_t'(1));
	assign wait_vec   = rail_en & ~pg_s2;

	assign timers_clr   = status.clear_err | ~sysen_s2 | err_found;
	assign wdog_expired = ~timers_clr & ~(|timing_vec) & (|wait_vec)
		& (w_count == WDOG_W'(WDOG_CYCLES - 1));

	// Settle delay and watchdog, delay takes priority
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			done    <= '0;
			d_count <= '0;
			w_count <= '0;
		end else if (status.clear_err) begin
			d_count <= '0;
			w_count <= '0;
		end else if (!sysen_s2 || err_found) begin
			done    <= '0;
			d_count <= '0;
			w_count <= '0;
		end else if (|timing_vec) begin
			w_count <= '0;
			if (d_count == DELAY_W'(DELAY_CYCLES - 1)) begin
				d_count <= '0;
				done    <= done | timing_sel;
			end else begin
				d_count <= d_count + 1'b1;
			end
		end else if (|wait_vec) begin
			if (wdog_expired) begin
				w_count <= '0;
			end else begin
				w_count <= w_count + 1'b1;
			end
		end
	end

	// Fault latches, held until software clears them
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			err_found     <= 1'b0;
		end else if (status.clear_err) begin
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			err_found     <= 1'b0;
		end else begin
			if (wdog_expired) begin
				wait_err <= 1'b1;
			end
			// A settled rail lost its power-good
			if (|(done & ~pg_s2)) begin
				operation_err <= 1'b1;
			end
			if (wait_err || operation_err) begin
				err_found <= 1'b1;
			end
		end
	end

	assign status.pg            = pg_s2;
	assign status.sysen         = sysen_s2;
	assign status.sysgood       = done[NUM_RAILS-1];
	assign status.wait_err      = wait_err;
	assign status.operation_err = operation_err;
	assign status.err_found     = err_found;

	// No rail comes up ahead of its predecessor while powering up
	a_en_order: assert property (@(posedge clk_in) disable iff (!arst_n)
		sysen_s2 |-> ((rail_en & ~$past(rail_en) & ~done_below) == '0));

	// A latched fault takes every rail down unless it is being cleared
	a_err_off: assert property (@(posedge clk_in) disable iff (!arst_n)
		(err_found && !status.clear_err) |=> (rail_en == '0));

endmodule

//--- hdl/status_regs.sv
`timescale 1ns/100ps
/*
 * Status register bank
 * Byte pointer with auto-increment on read, registered read data,
 * power-good snapshot frozen on error and the error-clear pulse
 */
module status_regs (
	input  logic                   clk_in,
	input  logic                   arst_n,
	input  logic                   reg_ptr_valid,
	input  pwr_seq_pkg::reg_addr_t reg_ptr,
	input  logic                   reg_read_req,
	output pwr_seq_pkg::reg_data_t reg_rdata,
	seq_status_if.regs             status
);
	import pwr_seq_pkg::*;

	reg_addr_t    ptr;
	logic         clear_err;
	rail_vec_t    pg_snap;
	status_bits_t status_byte;
	reg_data_t    rdata_next;

	// Pointer load wins over read advance
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			ptr       <= '0;
			clear_err <= 1'b0;
		end else begin
			clear_err <= reg_ptr_valid && (reg_ptr == ADDR_CLR_ERR);
			if (reg_ptr_valid) begin
				ptr <= reg_ptr;
			end else if (reg_read_req) begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	// Snapshot keeps the rail pattern seen when the fault hit
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			pg_snap <= '0;
		end else if (!status.err_found) begin
			pg_snap <= status.pg;
		end
	end

	assign status_byte = '{
		rsvd:          3'b000,
		wait_err:      status.wait_err,
		operation_err: status.operation_err,
		err_found:     status.err_found,
		sysen:         status.sysen,
		sysgood:       status.sysgood
	};

	always_comb begin
		case (ptr)
			ADDR_VERSION: rdata_next = FPGA_VERSION;
			ADDR_CLR_ERR: rdata_next = CLR_ERR_READBACK;
			ADDR_PG_HI:   rdata_next = {1'b0, pg_snap[14:8]};
			ADDR_PG_LO:   rdata_next = pg_snap[7:0];
			ADDR_STATUS:  rdata_next = status_byte;
			ADDR_VENDOR0: rdata_next = VENDOR_ID[0];
			ADDR_VENDOR1: rdata_next = VENDOR_ID[1];
			ADDR_VENDOR2: rdata_next = VENDOR_ID[2];
			ADDR_VENDOR3: rdata_next = VENDOR_ID[3];
			default:      rdata_next = '0;
		endcase
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			reg_rdata <= '0;
		end else begin
			reg_rdata <= rdata_next;
		end
	end

	assign status.clear_err = clear_err;

	// The sequencer expects a single-cycle clear
	a_clr_pulse: assert property (@(posedge clk_in) disable iff (!arst_n)
		clear_err |=> !clear_err);

endmodule

//--- hdl/pwr_seq_top.sv
`timescale 1ns/100ps
/*
 * Power sequencer top level
 * Joins the rail sequencer and the status register bank
 */
module pwr_seq_top (
	input  logic                   clk_in,
	input  logic                   arst_n,

	// System enable and rails
	input  logic                   sysen,
	input  pwr_seq_pkg::rail_vec_t rail_pg,
	output pwr_seq_pkg::rail_vec_t rail_en,
	output logic                   sysgood,

	// Register port
	input  logic                   reg_ptr_valid,
	input  pwr_seq_pkg::reg_addr_t reg_ptr,
	input  logic                   reg_read_req,
	output pwr_seq_pkg::reg_data_t reg_rdata
);

	seq_status_if status_bus ();

	rail_sequencer u_seq (
		.clk_in  (clk_in),
		.arst_n  (arst_n),
		.sysen   (sysen),
		.rail_pg (rail_pg),
		.rail_en (rail_en),
		.status  (status_bus.sequencer)
	);

	status_regs u_regs (
		.clk_in        (clk_in),
		.arst_n        (arst_n),
		.reg_ptr_valid (reg_ptr_valid),
		.reg_ptr       (reg_ptr),
		.reg_read_req  (reg_read_req),
		.reg_rdata     (reg_rdata),
		.status        (status_bus.regs)
	);

	// System power good follows the top rail's done flag
	assign sysgood = status_bus.sysgood;

endmodule

//--- sim/rail_model.sv
`timescale 1ns/100ps
/*
 * Regulator bank model
 * Each power-good follows its enable after a per-rail lag, with
 * stuck-low and drop fault controls
 */
module rail_model (
	input  logic                                   clk_in,
	input  logic                                   arst_n,
	input  pwr_seq_pkg::rail_vec_t                 rail_en,
	input  logic [pwr_seq_pkg::NUM_RAILS-1:0][3:0] lag,
	input  pwr_seq_pkg::rail_vec_t                 stuck_mask,
	input  pwr_seq_pkg::rail_vec_t                 drop_mask,
	output pwr_seq_pkg::rail_vec_t                 rail_pg
);
	import pwr_seq_pkg::*;

	rail_vec_t  level;
	logic [3:0] cnt [NUM_RAILS];

	// Output level follows the enable once the lag has run out
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			level <= '0;
			for (int i = 0; i < NUM_RAILS; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_RAILS; i++) begin
				if (drop_mask[i]) begin
					// Collapsed output
					level[i] <= 1'b0;
					cnt[i]   <= '0;
				end else if ((rail_en[i] & ~stuck_mask[i]) == level[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] + 4'd1 >= lag[i]) begin
					level[i] <= rail_en[i] & ~stuck_mask[i];
					cnt[i]   <= '0;
				end else begin
					cnt[i] <= cnt[i] + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			rail_pg <= '0;
		end else begin
			rail_pg <= level;
		end
	end

endmodule

//--- sim/pwr_seq_tb.sv
`timescale 1ns/100ps
/*
 * Power sequencer testbench
 * Closes the rail loop through a regulator model, injects faults
 * and checks the sequence and the status registers
 */
module pwr_seq_tb;
	import pwr_seq_pkg::*;

	typedef enum int {UNTIL_UP, UNTIL_DOWN, UNTIL_EN_OFF, UNTIL_PG_OFF, UNTIL_RAIL_ON} wait_kind_t;

	logic                      clk_in;
	logic                      arst_n;
	logic                      sysen;
	rail_vec_t                 rail_pg;
	rail_vec_t                 rail_en;
	logic                      sysgood;
	logic                      reg_ptr_valid;
	reg_addr_t                 reg_ptr;
	logic                      reg_read_req;
	reg_data_t                 reg_rdata;
	logic [NUM_RAILS-1:0][3:0] lag;
	rail_vec_t                 stuck_mask;
	rail_vec_t                 drop_mask;
	logic                      down_check;
	rail_vec_t                 prev_en;
	logic [31:0]               lfsr;
	int unsigned               r;
	int                        fault_rail;
	reg_data_t                 rd;
	reg_addr_t                 unmapped;
	string                     test_name;
	int                        checks;
	int                        errors;
	int                        timeouts;
	// Expected DUT state used by the register reference
	rail_vec_t                 exp_pg;
	logic                      exp_werr;
	logic                      exp_oerr;
	logic                      exp_sysen;
	logic                      exp_good;

	pwr_seq_top UUT (
		.clk_in        (clk_in),
		.arst_n        (arst_n),
		.sysen         (sysen),
		.rail_pg       (rail_pg),
		.rail_en       (rail_en),
		.sysgood       (sysgood),
		.reg_ptr_valid (reg_ptr_valid),
		.reg_ptr       (reg_ptr),
		.reg_read_req  (reg_read_req),
		.reg_rdata     (reg_rdata)
	);

	rail_model rails (
		.clk_in     (clk_in),
		.arst_n     (arst_n),
		.rail_en    (rail_en),
		.lag        (lag),
		.stuck_mask (stuck_mask),
		.drop_mask  (drop_mask),
		.rail_pg    (rail_pg)
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int unsigned val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | lfsr[0];
		end
	endtask

	function automatic rail_vec_t low_ones(input int n);
		rail_vec_t ones;
		ones = '1;
		return ~(ones << n);
	endfunction

	// Register byte expected at a pointer, from the register map
	function automatic reg_data_t expected_reg(input reg_addr_t addr, input rail_vec_t pg,
			input logic w_err, input logic o_err, input logic en, input logic good);
		case (addr)
			ADDR_VERSION: return 8'h06;
			ADDR_CLR_ERR: return 8'hFF;
			ADDR_PG_HI:   return {1'b0, pg[14:8]};
			ADDR_PG_LO:   return pg[7:0];
			ADDR_STATUS:  return {3'b000, w_err, o_err, w_err | o_err, en, good};
			// "RCS "
			ADDR_VENDOR0: return 8'h52;
			ADDR_VENDOR1: return 8'h43;
			ADDR_VENDOR2: return 8'h53;
			ADDR_VENDOR3: return 8'h20;
			default:      return 8'h00;
		endcase
	endfunction

	task automatic check_byte(input string name, input reg_data_t exp, input reg_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
		end
	endtask

	task automatic check_rails(input string name, input rail_vec_t exp, input rail_vec_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error [%s] %s: expected %b, actual %b", test_name, name, exp, act);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	function automatic logic wait_done(input wait_kind_t kind, input int k);
		case (kind)
			UNTIL_UP:      return sysgood === 1'b1;
			UNTIL_DOWN:    return sysgood === 1'b0;
			UNTIL_EN_OFF:  return rail_en === '0;
			UNTIL_PG_OFF:  return rail_pg === '0;
			UNTIL_RAIL_ON: return rail_en[k] === 1'b1;
			default:       return 1'b1;
		endcase
	endfunction

	task automatic wait_until(input wait_kind_t kind, input int k, input int limit,
			input string what);
		int n;
		n = 0;
		while (!wait_done(kind, k) && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		if (!wait_done(kind, k)) begin
			$display("Timeout in %s: no %s within %0d cycles", test_name, what, limit);
			timeouts++;
			finish_run();
		end
	endtask

	// Pointer load, the byte shows up two edges later
	task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
		@(negedge clk_in);
		reg_ptr_valid = 1'b1;
		reg_ptr       = addr;
		@(negedge clk_in);
		reg_ptr_valid = 1'b0;
		@(negedge clk_in);
		data = reg_rdata;
	endtask

	task automatic reg_read_next(output reg_data_t data);
		@(negedge clk_in);
		reg_read_req = 1'b1;
		@(negedge clk_in);
		reg_read_req = 1'b0;
		@(negedge clk_in);
		data = reg_rdata;
	endtask

	task automatic expect_state(input rail_vec_t pg, input logic w_err, input logic o_err,
			input logic en, input logic good);
		exp_pg    = pg;
		exp_werr  = w_err;
		exp_oerr  = o_err;
		exp_sysen = en;
		exp_good  = good;
	endtask

	task automatic read_expect(input reg_addr_t addr, input string name);
		reg_data_t data;
		reg_read(addr, data);
		check_byte(name, expected_reg(addr, exp_pg, exp_werr, exp_oerr, exp_sysen, exp_good),
			data);
	endtask

	task automatic power_down();
		down_check = 1'b1;
		sysen      = 1'b0;
		wait_until(UNTIL_DOWN, 0, 20, "sysgood fall");
		wait_until(UNTIL_EN_OFF, 0, 500, "all enables low");
		wait_until(UNTIL_PG_OFF, 0, 100, "all power-good low");
		down_check = 1'b0;
	endtask

	// Drain the rails, clear the latched fault, then power up again
	task automatic clear_and_restart();
		wait_until(UNTIL_PG_OFF, 0, 100, "rails drained before clear");
		read_expect(ADDR_CLR_ERR, "clear readback");
		expect_state(rail_pg, 1'b0, 1'b0, 1'b1, 1'b0);
		read_expect(ADDR_STATUS, "status after clear");
		wait_until(UNTIL_UP, 0, 2000, "sysgood after clear");
	endtask

	// Enables form one run of ones from rail 0, and go down from the top
	always @(negedge clk_in) begin
		if (arst_n) begin
			check_rails("enable run", low_ones($countones(rail_en)), rail_en);
			if (down_check) begin
				for (int i = 0; i < NUM_RAILS - 1; i++) begin
					if (prev_en[i] && !rail_en[i]) begin
						check_bit($sformatf("rail %0d power-good at rail %0d off", i + 1, i),
							1'b0, rail_pg[i + 1]);
					end
				end
			end
		end
		prev_en = rail_en;
	end

	initial begin
		arst_n        = 1'b0;
		sysen         = 1'b0;
		reg_ptr_valid = 1'b0;
		reg_ptr       = '0;
		reg_read_req  = 1'b0;
		stuck_mask    = '0;
		drop_mask     = '0;
		down_check    = 1'b0;
		checks        = 0;
		errors        = 0;
		timeouts      = 0;
		lfsr          = 32'h2c03_087e;
		test_name     = "reset";
		for (int i = 0; i < NUM_RAILS; i++) begin
			take_bits(3, r);
			lag[i] = 4'(r + 1);
		end
		repeat (2) @(posedge clk_in);
		@(negedge clk_in);
		arst_n = 1'b1;
		check_rails("enables", '0, rail_en);
		check_bit("sysgood", 1'b0, sysgood);
		check_byte("read data", '0, reg_rdata);

		test_name = "power-up";
		sysen = 1'b1;
		wait_until(UNTIL_UP, 0, 2000, "sysgood after power-up");
		check_rails("enables", '1, rail_en);
		expect_state(rail_pg, 1'b0, 1'b0, 1'b1, 1'b1);
		read_expect(ADDR_STATUS, "status");
		read_expect(ADDR_PG_HI, "power-good high");
		read_expect(ADDR_PG_LO, "power-good low");

		test_name = "id readback";
		read_expect(ADDR_VENDOR0, "vendor byte 0");
		for (int i = 1; i < 4; i++) begin
			reg_read_next(rd);
			check_byte($sformatf("vendor byte %0d", i),
				expected_reg(reg_addr_t'(ADDR_VENDOR0 + i), '0, 0, 0, 0, 0), rd);
		end
		take_bits(4, r);
		unmapped = reg_addr_t'(8'h10 + r);
		take_bits(1, r);
		for (int j = 0; j < 2; j++) begin
			read_expect((j[0] ^ r[0]) ? unmapped : ADDR_VERSION,
				(j[0] ^ r[0]) ? "unmapped" : "version");
		end

		test_name = "watchdog";
		power_down();
		take_bits(4, r);
		fault_rail = r % NUM_RAILS;
		stuck_mask = rail_vec_t'(1) << fault_rail;
		sysen = 1'b1;
		wait_until(UNTIL_RAIL_ON, fault_rail, 2000, "faulted rail enable");
		wait_until(UNTIL_EN_OFF, 0, 1000, "enables low after watchdog");
		// Power-good still shows the pattern at the moment of the fault
		check_rails("frozen rails", low_ones(fault_rail), rail_pg);
		expect_state(rail_pg, 1'b1, 1'b0, 1'b1, 1'b0);
		read_expect(ADDR_STATUS, "status");
		read_expect(ADDR_PG_HI, "frozen power-good high");
		read_expect(ADDR_PG_LO, "frozen power-good low");
		stuck_mask = '0;
		clear_and_restart();

		test_name = "operation error";
		take_bits(4, r);
		fault_rail = r % NUM_RAILS;
		drop_mask = rail_vec_t'(1) << fault_rail;
		wait_until(UNTIL_EN_OFF, 0, 100, "enables low after rail drop");
		expect_state(rail_pg, 1'b0, 1'b1, 1'b1, 1'b0);
		read_expect(ADDR_STATUS, "status");
		drop_mask = '0;
		clear_and_restart();

		test_name = "power-down";
		power_down();
		expect_state(rail_pg, 1'b0, 1'b0, 1'b0, 1'b0);
		read_expect(ADDR_STATUS, "status");
		finish_run();
	end

endmodule

//--- pwr_seq.f
hdl/pwr_seq_pkg.sv
hdl/seq_status_if.sv
hdl/rail_sequencer.sv
hdl/status_regs.sv
hdl/pwr_seq_top.sv
sim/rail_model.sv
sim/pwr_seq_tb.sv
